/* flist.f */
backend_pkg.sv
issue_fifo.sv
issue_dispatch.sv
alu_unit.sv
mul_control.sv
iteration_counter.sv
mul_datapath.sv
writeback_arbiter.sv
backend_top.sv
backend_props.sv
backend_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
TOP = backend_tb
FLIST = flist.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* backend_tb.sv */
// Credit-based stimulus for backend_top with a reference model and a compare process
// IDs wrap after 8 and are reused only once their writeback is seen
`timescale 1ns/1ps
`default_nettype none

module backend_tb;
    import backend_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_ALU = 4;
    localparam int N_MUL = 5;
    localparam int N_RANDOM = 200;
    localparam int N_B2B = 8;
    localparam int TOTAL_ISSUES = N_ALU + N_MUL + N_RANDOM + N_B2B;
    localparam int WATCHDOG_CYCLES = TOTAL_ISSUES * (MUL_ITERATIONS + 8) + RESET_CYCLES;
    localparam logic [31:0] SEED = 32'd8;

    logic clk;
    logic rst;
    logic issue_valid;
    issue_packet_t issue;
    logic credit_return;
    wb_packet_t wb;

    logic [XLEN-1:0] exp_data [1 << ID_W];
    bit [(1 << ID_W)-1:0] pending;
    id_t next_id;
    logic [31:0] rng;
    int credits;
    int issued;
    int returned;
    int wb_count;
    int errors;
    int checks;
    int tests;
    int failed_tests;
    bit saw_stall;

    backend_top UUT (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue),
        .credit_return(credit_return), .wb(wb)
    );

    bind backend_top backend_props props (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .credit_return(credit_return),
        .mul_start(mul_start), .mul_ready(mul_ready), .mul_valid(mul_valid),
        .mul_ack(mul_ack), .alu_valid(alu_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Reference model and random source
    function automatic logic [XLEN-1:0] ref_result(input issue_packet_t p);
        if (p.unit == UNIT_MUL)
            return p.a * p.b;
        case (p.op)
            ALU_ADD: return p.a + p.b;
            ALU_SUB: return p.a - p.b;
            ALU_AND: return p.a & p.b;
            default: return p.a ^ p.b;
        endcase
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////
    // Credit bookkeeping sampled on the edge
    always @(posedge clk) begin
        if (rst) begin
            credits <= ISSUE_DEPTH;
            issued <= 0;
            returned <= 0;
        end else begin
            credits <= credits - int'(issue_valid) + int'(credit_return);
            if (issue_valid)
                issued <= issued + 1;
            if (credit_return)
                returned <= returned + 1;
            if (credits > ISSUE_DEPTH) begin
                errors++;
                $display("%0t: credit count %0d is above the queue depth", $time, credits);
            end
        end
    end

    // Compare each writeback with the table entry of its ID
    always @(posedge clk) begin
        if (!rst && wb.valid) begin
            checks++;
            wb_count++;
            if (!pending[wb.id]) begin
                errors++;
                $display("%0t: writeback for ID %0d that is not in flight", $time, wb.id);
            end else if (wb.data !== exp_data[wb.id]) begin
                errors++;
                $display("mismatch at %0t: ID %0d result %h, expected %h",
                         $time, wb.id, wb.data, exp_data[wb.id]);
            end
            pending[wb.id] = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // Driver tasks
    task automatic send(input unit_id_t unit, input alu_op_t op,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        issue_packet_t p;
        while (credits == 0 || pending[next_id]) begin
            if (credits == 0)
                saw_stall = 1'b1;
            issue_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        p = '{id: next_id, unit: unit, op: op, a: a, b: b};
        exp_data[next_id] = ref_result(p);
        pending[next_id] = 1'b1;
        issue = p;
        issue_valid = 1'b1;
        next_id = next_id + 1'b1;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    // Wait until every issued ID has written back
    task automatic drain();
        while (pending != '0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors != errors_before)
            failed_tests++;
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        unit_id_t unit;
        alu_op_t op;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        pending = '0;
        next_id = '0;
        rng = SEED;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        wb_count = 0;
        saw_stall = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        repeat (8) begin
            @(posedge clk);
            #1;
            checks++;
            if (credit_return || wb.valid) begin
                errors++;
                $display("%0t: credit_return or wb.valid high before any issue", $time);
            end
        end
        finish_test("reset_idle", e0);

        e0 = errors;
        send(UNIT_ALU, ALU_ADD, 32'h7fff_ffff, 32'h0000_0001);
        send(UNIT_ALU, ALU_SUB, 32'h0000_0000, 32'h0000_0001);
        send(UNIT_ALU, ALU_AND, 32'hf0f0_1234, 32'h0ff0_ffff);
        send(UNIT_ALU, ALU_XOR, 32'haaaa_5555, 32'hffff_0000);
        drain();
        finish_test("alu_directed", e0);

        e0 = errors;
        send(UNIT_MUL, ALU_ADD, 32'h0000_0000, 32'h1234_5678);
        send(UNIT_MUL, ALU_ADD, 32'h0000_0001, 32'hdead_beef);
        send(UNIT_MUL, ALU_ADD, 32'hffff_ffff, 32'hffff_ffff);
        send(UNIT_MUL, ALU_ADD, 32'hffff_ffff, 32'h0000_0002);
        send(UNIT_MUL, ALU_ADD, 32'h1234_5678, 32'h9abc_def0);
        drain();
        finish_test("mul_directed", e0);

        e0 = errors;
        repeat (N_RANDOM) begin
            rng = xorshift(rng);
            unit = unit_id_t'(rng[0]);
            op = alu_op_t'(rng[2:1]);
            rng = xorshift(rng);
            a = rng;
            rng = xorshift(rng);
            b = rng;
            send(unit, op, a, b);
        end
        drain();
        finish_test("random_mix", e0);

        // Queue fills behind the busy multiplier
        e0 = errors;
        saw_stall = 1'b0;
        for (int i = 0; i < N_B2B; i++) begin
            rng = xorshift(rng);
            send(UNIT_MUL, ALU_ADD, rng, 32'(i * 3 + 1));
        end
        drain();
        checks++;
        if (!saw_stall) begin
            errors++;
            $display("%0t: credits never ran out during back-to-back multiplies", $time);
        end
        finish_test("mul_backpressure", e0);

        e0 = errors;
        checks++;
        if (credits != ISSUE_DEPTH || returned != issued || wb_count != issued) begin
            errors++;
            $display("%0t: credits %0d, issued %0d, returned %0d, written back %0d",
                     $time, credits, issued, returned, wb_count);
        end
        finish_test("credit_accounting", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* backend_props.sv */
// Protocol checks for backend_top attached with bind from the testbench
// All checks are off while rst is high
`timescale 1ns/1ps
`default_nettype none

module backend_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic issue_valid,
    input wire logic credit_return,
    input wire logic mul_start,
    input wire logic mul_ready,
    input wire logic mul_valid,
    input wire logic mul_ack,
    input wire logic alu_valid
);

    int occupancy;
    logic mul_busy;

    // Queue occupancy rebuilt from pushes and returned credits
    always_ff @(posedge clk) begin
        if (rst)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(issue_valid) - int'(credit_return);
    end

    // Multiply in flight from start until its ack
    always_ff @(posedge clk) begin
        if (rst)
            mul_busy <= 1'b0;
        else if (mul_start)
            mul_busy <= 1'b1;
        else if (mul_ack)
            mul_busy <= 1'b0;
    end

    // A credit only goes back for a popped entry
    credit_from_queue: assert property (@(posedge clk) disable iff (rst)
        credit_return |-> (occupancy != 0))
        else $error("credit returned while the issue queue was empty");

    // A held product blocks the next multiply
    mul_busy_while_valid: assert property (@(posedge clk) disable iff (rst)
        (mul_valid || mul_busy) |-> (mul_busy && !mul_ready))
        else $error("multiplier ready before its result was acknowledged");

    // The ALU keeps its result while the multiplier takes the port
    one_ack_per_cycle: assert property (@(posedge clk) disable iff (rst)
        (alu_valid && mul_valid) |=> alu_valid)
        else $error("ALU result dropped in a cycle that acknowledged the multiplier");

endmodule

`default_nettype wire

/* backend_top.sv */
// Issue queue, dispatcher, ALU, multiplier and writeback arbiter
// Upstream must follow the credit protocol: ISSUE_DEPTH credits after reset
`timescale 1ns/1ps
`default_nettype none

module backend_top (
    input wire logic clk,
    input wire logic rst,
    input wire logic issue_valid,
    input wire backend_pkg::issue_packet_t issue,
    output logic credit_return,
    output backend_pkg::wb_packet_t wb
);
    import backend_pkg::*;

    issue_packet_t head;
    logic not_empty;
    logic pop;
    logic alu_start;
    logic mul_start;
    logic alu_ready;
    logic mul_ready;
    logic alu_valid;
    logic mul_valid;
    logic alu_ack;
    logic mul_ack;
    unit_result_t alu_result;
    unit_result_t mul_result;
    logic mul_load;
    logic mul_step;
    logic mul_last;

    //////////////////////////////
    // Issue side
    issue_fifo issue_q (
        .clk(clk), .rst(rst), .push(issue_valid), .din(issue),
        .pop(pop), .head(head), .not_empty(not_empty)
    );

    issue_dispatch dispatch (
        .head(head), .not_empty(not_empty),
        .alu_ready(alu_ready), .mul_ready(mul_ready),
        .alu_start(alu_start), .mul_start(mul_start),
        .pop(pop), .credit_return(credit_return)
    );

    //////////////////////////////
    // Execution units
    alu_unit alu (
        .clk(clk), .rst(rst), .start(alu_start), .op(head), .ack(alu_ack),
        .ready(alu_ready), .result_valid(alu_valid), .result(alu_result)
    );

    mul_control mul_ctrl (
        .clk(clk), .rst(rst), .start(mul_start), .last(mul_last), .ack(mul_ack),
        .load(mul_load), .step(mul_step), .ready(mul_ready), .result_valid(mul_valid)
    );

    iteration_counter mul_cnt (
        .clk(clk), .rst(rst), .load(mul_load), .step(mul_step), .last(mul_last)
    );

    mul_datapath mul_dp (
        .clk(clk), .rst(rst), .load(mul_load), .step(mul_step),
        .op(head), .result(mul_result)
    );

    //////////////////////////////
    // Writeback
    writeback_arbiter wb_arb (
        .clk(clk), .rst(rst),
        .alu_valid(alu_valid), .alu_result(alu_result),
        .mul_valid(mul_valid), .mul_result(mul_result),
        .alu_ack(alu_ack), .mul_ack(mul_ack), .wb(wb)
    );

endmodule

`default_nettype wire

/* writeback_arbiter.sv */
// Fixed priority, multiplier over ALU; the loser keeps holding its result
// wb has no back-pressure and is registered, one cycle after ack
`timescale 1ns/1ps
`default_nettype none

module writeback_arbiter (
    input wire logic clk,
    input wire logic rst,
    input wire logic alu_valid,
    input wire backend_pkg::unit_result_t alu_result,
    input wire logic mul_valid,
    input wire backend_pkg::unit_result_t mul_result,
    output logic alu_ack,
    output logic mul_ack,
    output backend_pkg::wb_packet_t wb
);
    import backend_pkg::*;

    logic wb_valid;
    unit_result_t wb_result;

    assign mul_ack = mul_valid;
    assign alu_ack = alu_valid & ~mul_valid;

    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= alu_ack | mul_ack;
    end

    always_ff @(posedge clk) begin
        wb_result <= mul_valid ? mul_result : alu_result;
    end

    assign wb = '{valid: wb_valid, id: wb_result.id, data: wb_result.data};

endmodule

`default_nettype wire

/* mul_datapath.sv */
// Radix-2 shift-add datapath, one multiplier bit per step
// Only the low XLEN bits are kept, so the multiplicand shifts out its upper bits
`timescale 1ns/1ps
`default_nettype none

module mul_datapath (
    input wire logic clk,
    input wire logic rst,
    input wire logic load,
    input wire logic step,
    input wire backend_pkg::issue_packet_t op,
    output backend_pkg::unit_result_t result
);
    import backend_pkg::*;

    logic [XLEN-1:0] multiplicand;
    logic [XLEN-1:0] multiplier;
    logic [XLEN-1:0] acc;
    id_t result_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            multiplicand <= '0;
            multiplier <= '0;
            acc <= '0;
            result_id <= '0;
        end else if (load) begin
            multiplicand <= op.a;
            multiplier <= op.b;
            acc <= '0;
            result_id <= op.id;
        end else if (step) begin
            // Add the shifted multiplicand for each set multiplier bit
            if (multiplier[0])
                acc <= acc + multiplicand;
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
        end
    end

    assign result = '{id: result_id, data: acc};

endmodule

`default_nettype wire

/* iteration_counter.sv */
// Counts the multiplier steps down from MUL_ITERATIONS - 1
// last is only meaningful while step is high
`timescale 1ns/1ps
`default_nettype none

module iteration_counter (
    input wire logic clk,
    input wire logic rst,
    input wire logic load,
    input wire logic step,
    output logic last
);
    import backend_pkg::*;

    localparam int CNT_W = $clog2(MUL_ITERATIONS);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else if (load)
            count <= CNT_W'(MUL_ITERATIONS - 1);
        else if (step)
            count <= count - 1'b1;
    end

    assign last = step & (count == '0);

endmodule

`default_nettype wire

/* mul_control.sv */
// Multiplier sequencer: IDLE accepts a start, RUN steps until last, DONE holds the result
// ready is only high in IDLE, so a held result always blocks the next multiply
`timescale 1ns/1ps
`default_nettype none

module mul_control (
    input wire logic clk,
    input wire logic rst,
    input wire logic start,
    input wire logic last,
    input wire logic ack,
    output logic load,
    output logic step,
    output logic ready,
    output logic result_valid
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_t;

    state_t state;
    state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (start) next_state = RUN;
            RUN: if (last) next_state = DONE;
            DONE: if (ack) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    assign load = start & (state == IDLE);
    assign step = (state == RUN);
    assign ready = (state == IDLE);
    assign result_valid = (state == DONE);

endmodule

`default_nettype wire

/* alu_unit.sv */
// Single-cycle ALU with one result register
// A result that is not acked blocks new starts until the arbiter takes it
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input wire logic clk,
    input wire logic rst,
    input wire logic start,
    input wire backend_pkg::issue_packet_t op,
    input wire logic ack,
    output logic ready,
    output logic result_valid,
    output backend_pkg::unit_result_t result
);
    import backend_pkg::*;

    logic [XLEN-1:0] alu_out;

    always_comb begin
        case (op.op)
            ALU_ADD: alu_out = op.a + op.b;
            ALU_SUB: alu_out = op.a - op.b;
            ALU_AND: alu_out = op.a & op.b;
            default: alu_out = op.a ^ op.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            result_valid <= 1'b0;
        else if (start)
            result_valid <= 1'b1;
        else if (ack)
            result_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start)
            result <= '{id: op.id, data: alu_out};
    end

    // Free when empty, or when the held result leaves this cycle
    assign ready = ~result_valid | ack;

endmodule

`default_nettype wire

/* issue_dispatch.sv */
// Strictly in-order dispatch: a busy target unit stalls the queue head
// One credit goes back upstream in the same cycle as each pop
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch (
    input wire backend_pkg::issue_packet_t head,
    input wire logic not_empty,
    input wire logic alu_ready,
    input wire logic mul_ready,
    output logic alu_start,
    output logic mul_start,
    output logic pop,
    output logic credit_return
);
    import backend_pkg::*;

    logic head_is_alu;
    logic head_is_mul;

    // Unit ID decode of the head packet
    assign head_is_alu = (head.unit == UNIT_ALU);
    assign head_is_mul = (head.unit == UNIT_MUL);

    assign alu_start = not_empty & head_is_alu & alu_ready;
    assign mul_start = not_empty & head_is_mul & mul_ready;

    // Starts are exclusive since the head names one unit
    assign pop = alu_start | mul_start;
    assign credit_return = pop;

endmodule

`default_nettype wire

/* issue_fifo.sv */
// Show-ahead issue queue; the head is valid whenever not_empty is high
// No full flag: upstream credits bound occupancy to ISSUE_DEPTH
`timescale 1ns/1ps
`default_nettype none

module issue_fifo (
    input wire logic clk,
    input wire logic rst,
    input wire logic push,
    input wire backend_pkg::issue_packet_t din,
    input wire logic pop,
    output backend_pkg::issue_packet_t head,
    output logic not_empty
);
    import backend_pkg::*;

    localparam int PTR_W = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(ISSUE_DEPTH + 1);

    issue_packet_t mem [ISSUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Storage, no reset needed
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

`default_nettype wire

/* backend_pkg.sv */
// Shared widths, unit IDs, ALU opcodes and bus structs for the issue/writeback backend
// Unit IDs are fixed because both execution units are always present
`default_nettype none

package backend_pkg;

    //////////////////////////////
    // Widths and sizes
    localparam int XLEN = 32;
    localparam int ID_W = 3;
    localparam int ISSUE_DEPTH = 4;
    localparam int NUM_UNITS = 2;
    localparam int UNIT_W = $clog2(NUM_UNITS);
    localparam int MUL_ITERATIONS = XLEN;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [UNIT_W-1:0] unit_id_t;

    // Fixed unit IDs, index into the dispatcher decode
    localparam unit_id_t UNIT_ALU = unit_id_t'(0);
    localparam unit_id_t UNIT_MUL = unit_id_t'(1);

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_t;

    //////////////////////////////
    // Packets
    typedef struct packed {
        id_t id;
        unit_id_t unit;
        alu_op_t op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } issue_packet_t;

    typedef struct packed {
        id_t id;
        logic [XLEN-1:0] data;
    } unit_result_t;

    typedef struct packed {
        logic valid;
        id_t id;
        logic [XLEN-1:0] data;
    } wb_packet_t;

endpackage

`default_nettype wire
